//--- verification/pic_stim.txt
# P address word (hex): program word, B value / C value (hex): next port write
# N count (decimal): instruction slots the program needs
N 122
# literal ops, results to port B
P 000 303c
P 001 008d
P 002 3ee0
P 003 008d
P 004 3c10
P 005 008d
P 006 393f
P 007 008d
P 008 3881
P 009 008d
P 00a 3aff
P 00b 008d
# file ops on 0x20, results to port C
P 00c 3096
P 00d 00a0
P 00e 3021
P 00f 0720
P 010 008e
P 011 07a0
P 012 0820
P 013 008e
P 014 300f
P 015 0220
P 016 008e
P 017 02a0
P 018 0aa0
P 019 0a20
P 01a 008e
P 01b 0320
P 01c 008e
P 01d 03a0
P 01e 0920
P 01f 008e
P 020 09a0
P 021 3720
P 022 008e
P 023 35a0
P 024 0820
P 025 008e
P 026 3620
P 027 008e
P 028 0da0
P 029 0d20
P 02a 008e
P 02b 0c20
P 02c 008e
P 02d 0ca0
P 02e 0e20
P 02f 008e
P 030 0ea0
P 031 0820
P 032 3e01
P 033 008e
P 034 0100
P 035 3a5a
P 036 008e
P 037 01a0
P 038 0820
P 039 3e33
P 03a 008e
P 03b 30c3
P 03c 00a0
P 03d 305a
P 03e 0520
P 03f 008e
P 040 04a0
P 041 0620
P 042 008e
# bit ops on 0x21, marker ee must never reach port B
P 043 300f
P 044 00a1
P 045 1121
P 046 17a1
P 047 0821
P 048 008d
P 049 3021
P 04a 1921
P 04b 30ee
P 04c 008d
P 04d 3044
P 04e 1fa1
P 04f 30ee
P 050 008d
P 051 1821
P 052 3099
P 053 008d
# goto, call and return, then a decfsz loop on 0x22
P 054 2857
P 055 30ee
P 056 008d
P 057 2070
P 058 3077
P 059 008d
P 05a 3005
P 05b 00a2
P 05c 0822
P 05d 008d
P 05e 0ba2
P 05f 285c
P 060 30a5
P 061 008d
P 062 2862
# subroutine
P 070 303d
P 071 008e
P 072 0008
# expected port B writes
B 3c
B 1c
B f4
B 34
B b5
B 4a
B 8b
B 21
B 44
B 99
B 77
B 05
B 04
B 03
B 02
B 01
B a5
# expected port C writes
C b7
C 4d
C 3e
C 11
C 0f
C f0
C f8
C e0
C 70
C 83
C e0
C 0e
C 0f
C 5a
C 33
C 42
C 81
C 3d

//--- sources.f
src/pic_pkg.sv
src/program_rom.sv
src/call_stack.sv
src/fetch_unit.sv
src/data_space.sv
src/alu.sv
src/sequencer.sv
src/pic_core.sv
verification/pic_checker.sv
verification/tb_pic_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pic_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
STIM      ?= verification/pic_stim.txt
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM) $(STIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_pic_core.sv
module tb_pic_core;
    timeunit 1ns;
    timeprecision 100ps;

    import pic_pkg::*;

    localparam string stim_path = "verification/pic_stim.txt";

    logic                   clk;
    logic                   reset;
    logic                   prog_we;
    logic [pc_width-1:0]    prog_addr;
    logic [instr_width-1:0] prog_data;
    logic [data_width-1:0]  w;
    logic [data_width-1:0]  port_b;
    logic [data_width-1:0]  port_c;
    logic                   end_of_run;
    logic                   all_seen;
    int                     check_count;
    int                     check_errors;

    int                     errors;
    int                     cycle;
    int                     limit;
    int                     run_slots;
    logic [pc_width-1:0]    load_addr [$];
    logic [instr_width-1:0] load_word [$];

    pic_core #(.stack_depth(8)) uut (
        .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .w(w), .port_b(port_b), .port_c(port_c)
    );

    pic_checker port_check (
        .clk(clk), .reset(reset), .end_of_run(end_of_run), .w(w),
        .port_b(port_b), .port_c(port_c), .all_seen(all_seen),
        .checks(check_count), .errors(check_errors)
    );

    always #20 clk = ~clk;

    // program words and the slot count
    task automatic read_program();
        int    fd;
        int    code;
        int    a;
        int    b;
        byte   kind;
        string line;
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("cannot open %s for reading", stim_path);
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            kind = line[0];
            if (kind == "P") begin
                code = $sscanf(line, "%c %h %h", kind, a, b);
                load_addr.push_back(a[pc_width-1:0]);
                load_word.push_back(b[instr_width-1:0]);
            end else if (kind == "N") begin
                code = $sscanf(line, "%c %d", kind, a);
                run_slots = a;
            end
        end
        $fclose(fd);
    endtask

    task automatic load_program();
        for (int i = 0; i < load_addr.size(); i++) begin
            @(posedge clk);
            #2;
            prog_we   = 1'b1;
            prog_addr = load_addr[i];
            prog_data = load_word[i];
        end
        @(posedge clk);
        #2;
        prog_we = 1'b0;
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        end_of_run = 1'b0;
        errors     = 0;
        run_slots  = 0;
        cycle      = 0;

        read_program();
        load_program();

        // reset cycles, start-up fetch, three cycles a slot, then slack
        limit = 16 + 4 + 3 * run_slots + 32;
        repeat (16) begin
            @(posedge clk);
            cycle++;
        end
        #2;
        reset = 1'b0;

        while (!all_seen && cycle < limit) begin
            @(posedge clk);
            cycle++;
        end
        if (!all_seen) begin
            $display("timeout before all expected port writes");
            errors++;
        end else begin
            // a little longer to catch stray writes
            repeat (8) @(posedge clk);
        end

        #2;
        end_of_run = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        $display("checks %0d, check errors %0d, other errors %0d, cycles %0d",
                 check_count, check_errors, errors, cycle);
        if (errors == 0 && check_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verification/pic_checker.sv
module pic_checker (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           end_of_run,
    input  logic [pic_pkg::data_width-1:0] w,
    input  logic [pic_pkg::data_width-1:0] port_b,
    input  logic [pic_pkg::data_width-1:0] port_c,
    output logic                           all_seen,
    output int                             checks,
    output int                             errors
);
    timeunit 1ns;
    timeprecision 100ps;

    import pic_pkg::*;

    localparam string stim_path = "verification/pic_stim.txt";

    logic [data_width-1:0] expect_b [$];
    logic [data_width-1:0] expect_c [$];
    logic [data_width-1:0] last_b;
    logic [data_width-1:0] last_c;
    int                    count_b;
    int                    count_c;
    int                    since_reset;
    logic                  reported;

    task automatic read_expected();
        int    fd;
        int    code;
        int    v;
        byte   kind;
        string line;
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("cannot open %s for the expected port writes", stim_path);
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            code = $sscanf(line, "%c %h", kind, v);
            if (kind == "B") begin
                expect_b.push_back(v[data_width-1:0]);
            end else if (kind == "C") begin
                expect_c.push_back(v[data_width-1:0]);
            end
        end
        $fclose(fd);
    endtask

    task automatic compare(input string test_name, input logic [data_width-1:0] expected,
                           input logic [data_width-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s expected %02h actual %02h", test_name, expected, actual);
        end
    endtask

    initial begin
        all_seen    = 1'b0;
        checks      = 0;
        errors      = 0;
        count_b     = 0;
        count_c     = 0;
        since_reset = 0;
        reported    = 1'b0;
        last_b      = '0;
        last_c      = '0;
        read_expected();
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin : watch
        logic [data_width-1:0] exp_value;
        if (reset) begin
            // first falling edge after release comes before any active edge
            since_reset = -1;
            if (w !== '0 || port_b !== '0 || port_c !== '0) begin
                errors++;
                $display("w or a port is not zero during reset");
            end
        end else begin
            since_reset++;
            if ((port_b !== last_b || port_c !== last_c) && since_reset < 5) begin
                errors++;
                $display("a port changed only %0d cycles after reset", since_reset);
            end
            if (port_b !== last_b) begin
                count_b++;
                if (expect_b.size() == 0) begin
                    errors++;
                    $display("port B written with %02h but no write was expected", port_b);
                end else begin
                    exp_value = expect_b.pop_front();
                    compare($sformatf("port_b write %0d", count_b), exp_value, port_b);
                end
                last_b = port_b;
            end
            if (port_c !== last_c) begin
                count_c++;
                if (expect_c.size() == 0) begin
                    errors++;
                    $display("port C written with %02h but no write was expected", port_c);
                end else begin
                    exp_value = expect_c.pop_front();
                    compare($sformatf("port_c write %0d", count_c), exp_value, port_c);
                end
                last_c = port_c;
            end
        end
        all_seen = (expect_b.size() == 0) && (expect_c.size() == 0);
        if (end_of_run && !reported) begin
            reported = 1'b1;
            if (expect_b.size() != 0 || expect_c.size() != 0) begin
                errors++;
                $display("port writes never seen: %0d on port B, %0d on port C",
                         expect_b.size(), expect_c.size());
            end
        end
    end

endmodule

//--- src/pic_core.sv
module pic_core #(
    parameter int stack_depth = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            prog_we,
    input  logic [pic_pkg::pc_width-1:0]    prog_addr,
    input  logic [pic_pkg::instr_width-1:0] prog_data,
    output logic [pic_pkg::data_width-1:0]  w,
    output logic [pic_pkg::data_width-1:0]  port_b,
    output logic [pic_pkg::data_width-1:0]  port_c
);
    import pic_pkg::*;

    logic [pc_width-1:0]    pc;
    logic [pc_width-1:0]    mar;
    logic [pc_width-1:0]    stack_top;
    logic [instr_width-1:0] rom_data;
    logic [instr_width-1:0] ir;
    logic [data_width-1:0]  file_data;
    logic [data_width-1:0]  alu_result;
    logic                   zero;
    logic                   pc_load;
    pc_sel_t                pc_sel;
    logic                   mar_load;
    logic                   ir_load;
    logic                   ir_clear;
    logic                   push;
    logic                   pop;
    operand_sel_t           operand_sel;
    alu_op_t                alu_op;
    logic                   w_load;
    logic                   file_we;
    logic                   store_w;

    program_rom u_rom (
        .clk(clk), .we(prog_we), .write_addr(prog_addr), .write_data(prog_data),
        .read_addr(mar), .read_data(rom_data)
    );

    call_stack #(.depth(stack_depth)) u_stack (
        .clk(clk), .reset(reset), .push(push), .pop(pop),
        .return_addr(pc), .top(stack_top)
    );

    fetch_unit u_fetch (
        .clk(clk), .reset(reset), .pc_load(pc_load), .pc_sel(pc_sel),
        .mar_load(mar_load), .ir_load(ir_load), .ir_clear(ir_clear),
        .stack_top(stack_top), .rom_data(rom_data), .pc(pc), .mar(mar), .ir(ir)
    );

    data_space u_data (
        .clk(clk), .reset(reset), .ir(ir), .file_we(file_we), .store_w(store_w),
        .alu_result(alu_result), .w(w), .file_data(file_data),
        .port_b(port_b), .port_c(port_c)
    );

    alu u_alu (
        .clk(clk), .reset(reset), .ir(ir), .file_data(file_data),
        .operand_sel(operand_sel), .alu_op(alu_op), .w_load(w_load),
        .result(alu_result), .zero(zero), .w(w)
    );

    sequencer u_seq (
        .clk(clk), .reset(reset), .ir(ir), .file_data(file_data), .zero(zero),
        .pc_load(pc_load), .pc_sel(pc_sel), .mar_load(mar_load),
        .ir_load(ir_load), .ir_clear(ir_clear), .push(push), .pop(pop),
        .operand_sel(operand_sel), .alu_op(alu_op), .w_load(w_load),
        .file_we(file_we), .store_w(store_w)
    );

endmodule

//--- src/sequencer.sv
module sequencer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [pic_pkg::instr_width-1:0] ir,
    input  logic [pic_pkg::data_width-1:0]  file_data,
    input  logic                            zero,
    output logic                            pc_load,
    output pic_pkg::pc_sel_t                pc_sel,
    output logic                            mar_load,
    output logic                            ir_load,
    output logic                            ir_clear,
    output logic                            push,
    output logic                            pop,
    output pic_pkg::operand_sel_t           operand_sel,
    output pic_pkg::alu_op_t                alu_op,
    output logic                            w_load,
    output logic                            file_we,
    output logic                            store_w
);
    import pic_pkg::*;

    typedef enum logic [3:0] {
        cls_nop, cls_literal, cls_file, cls_clrf, cls_clrw, cls_movwf, cls_bcf,
        cls_bsf, cls_btfsc, cls_btfss, cls_count_skip, cls_goto, cls_call, cls_return
    } instr_class_t;

    instr_class_t cls;
    alu_op_t      decoded_op;
    cycle_t       state;
    cycle_t       next_state;
    logic         dest_file;
    logic         tested_bit;

    assign dest_file  = ir[7];
    assign tested_bit = file_data[ir[9:7]];

    always_comb begin
        case (ir[13:8])
            6'h3e, 6'h07:        decoded_op = alu_add;
            6'h3c, 6'h02:        decoded_op = alu_sub;
            6'h39, 6'h05:        decoded_op = alu_and;
            6'h38, 6'h04:        decoded_op = alu_or;
            6'h3a, 6'h06:        decoded_op = alu_xor;
            6'h0a, 6'h0f:        decoded_op = alu_inc;
            6'h03, 6'h0b:        decoded_op = alu_dec;
            6'h01:               decoded_op = alu_zero;
            6'h09:               decoded_op = alu_invert;
            6'h37:               decoded_op = alu_asr;
            6'h35:               decoded_op = alu_lsl;
            6'h36:               decoded_op = alu_lsr;
            6'h0d:               decoded_op = alu_rl;
            6'h0c:               decoded_op = alu_rr;
            6'h0e:               decoded_op = alu_swap;
            default:             decoded_op = alu_pass;
        endcase
    end

    always_comb begin
        cls = cls_nop;
        casez (ir[13:8])
            6'h30, 6'h38, 6'h39, 6'h3a, 6'h3c, 6'h3e: cls = cls_literal;
            6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h08, 6'h09,
            6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h35, 6'h36, 6'h37: cls = cls_file;
            6'h0b, 6'h0f: cls = cls_count_skip;
            6'h01:        cls = ir[7] ? cls_clrf : cls_clrw;
            6'h00: begin
                if (ir[7]) begin
                    cls = cls_movwf;
                end else if (ir[7:0] == 8'h08) begin
                    cls = cls_return;
                end
            end
            6'b01_00??: cls = cls_bcf;
            6'b01_01??: cls = cls_bsf;
            6'b01_10??: cls = cls_btfsc;
            6'b01_11??: cls = cls_btfss;
            6'b10_0???: cls = cls_call;
            6'b10_1???: cls = cls_goto;
            default:    cls = cls_nop;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetch_clear;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        pc_load     = 1'b0;
        pc_sel      = pc_inc;
        mar_load    = 1'b0;
        ir_load     = 1'b0;
        ir_clear    = 1'b0;
        push        = 1'b0;
        pop         = 1'b0;
        operand_sel = opnd_file;
        alu_op      = decoded_op;
        w_load      = 1'b0;
        file_we     = 1'b0;
        store_w     = 1'b0;
        next_state  = fetch_clear;
        unique case (state)
            fetch_clear: begin
                ir_clear   = 1'b1;
                next_state = fetch_addr;
            end
            fetch_addr: begin
                mar_load   = 1'b1;
                pc_load    = 1'b1;
                next_state = fetch_wait;
            end
            fetch_wait: next_state = fetch_load;
            fetch_load: begin
                ir_load    = 1'b1;
                next_state = execute;
            end
            execute: begin
                // prefetch address goes out while this instruction runs
                mar_load   = 1'b1;
                pc_load    = 1'b1;
                next_state = redirect;
                case (cls)
                    cls_literal: begin
                        operand_sel = opnd_literal;
                        w_load      = 1'b1;
                    end
                    cls_file: begin
                        w_load  = !dest_file;
                        file_we = dest_file;
                    end
                    cls_clrf:  file_we = 1'b1;
                    cls_clrw:  w_load = 1'b1;
                    cls_movwf: begin
                        store_w = 1'b1;
                        file_we = 1'b1;
                    end
                    cls_bcf, cls_bsf: begin
                        operand_sel = (cls == cls_bcf) ? opnd_bit_clear : opnd_bit_set;
                        alu_op      = alu_pass;
                        file_we     = 1'b1;
                    end
                    // pc already points past the call
                    cls_call:  push = 1'b1;
                    default: ;
                endcase
            end
            redirect: begin
                next_state = prefetch;
                if (cls == cls_goto || cls == cls_call) begin
                    pc_load = 1'b1;
                    pc_sel  = pc_jump;
                end else if (cls == cls_return) begin
                    pop     = 1'b1;
                    pc_load = 1'b1;
                    pc_sel  = pc_stack;
                end
            end
            prefetch: begin
                ir_load    = 1'b1;
                next_state = execute;
                case (cls)
                    cls_goto, cls_call, cls_return: ir_clear = 1'b1;
                    cls_btfsc: ir_clear = !tested_bit;
                    cls_btfss: ir_clear = tested_bit;
                    cls_count_skip: begin
                        w_load   = !dest_file;
                        file_we  = dest_file;
                        ir_clear = zero;
                    end
                    default: ;
                endcase
            end
            default: next_state = fetch_clear;
        endcase
    end

    // one destination per instruction, across every cycle of the loop
    single_dest: assert property (@(posedge clk) disable iff (reset) !(file_we && w_load));

endmodule

//--- src/alu.sv
module alu (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [pic_pkg::instr_width-1:0] ir,
    input  logic [pic_pkg::data_width-1:0]  file_data,
    input  pic_pkg::operand_sel_t           operand_sel,
    input  pic_pkg::alu_op_t                alu_op,
    input  logic                            w_load,
    output logic [pic_pkg::data_width-1:0]  result,
    output logic                            zero,
    output logic [pic_pkg::data_width-1:0]  w
);
    import pic_pkg::*;

    logic [data_width-1:0] bit_mask;
    logic [data_width-1:0] operand;

    // bit number in ir[9:7] for bcf and bsf
    assign bit_mask = {{(data_width-1){1'b0}}, 1'b1} << ir[9:7];

    always_comb begin
        unique case (operand_sel)
            opnd_literal:   operand = ir[data_width-1:0];
            opnd_bit_clear: operand = file_data & ~bit_mask;
            opnd_bit_set:   operand = file_data | bit_mask;
            default:        operand = file_data;
        endcase
    end

    always_comb begin
        result = operand;
        unique case (alu_op)
            alu_add:    result = operand + w;
            alu_sub:    result = operand - w;
            alu_and:    result = operand & w;
            alu_or:     result = operand | w;
            alu_xor:    result = operand ^ w;
            alu_pass:   result = operand;
            alu_inc:    result = operand + 1'b1;
            alu_dec:    result = operand - 1'b1;
            alu_zero:   result = '0;
            alu_invert: result = ~operand;
            alu_asr:    result = {operand[7], operand[7:1]};
            alu_lsl:    result = {operand[6:0], 1'b0};
            alu_lsr:    result = {1'b0, operand[7:1]};
            alu_rl:     result = {operand[6:0], operand[7]};
            alu_rr:     result = {operand[0], operand[7:1]};
            alu_swap:   result = {operand[3:0], operand[7:4]};
        endcase
    end

    // decfsz and incfsz skip on this
    assign zero = (result == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            w <= '0;
        end else if (w_load) begin
            w <= result;
        end
    end

endmodule

//--- src/data_space.sv
module data_space (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [pic_pkg::instr_width-1:0] ir,
    input  logic                            file_we,
    input  logic                            store_w,
    input  logic [pic_pkg::data_width-1:0]  alu_result,
    input  logic [pic_pkg::data_width-1:0]  w,
    output logic [pic_pkg::data_width-1:0]  file_data,
    output logic [pic_pkg::data_width-1:0]  port_b,
    output logic [pic_pkg::data_width-1:0]  port_c
);
    import pic_pkg::*;

    logic [data_width-1:0]      ram [2**file_addr_width];
    logic [file_addr_width-1:0] file_addr;
    logic [data_width-1:0]      write_data;

    assign file_addr  = ir[file_addr_width-1:0];
    assign write_data = store_w ? w : alu_result;

    always_ff @(posedge clk) begin
        if (file_we && file_addr != port_b_addr && file_addr != port_c_addr) begin
            ram[file_addr] <= write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            port_b <= '0;
            port_c <= '0;
        end else if (file_we) begin
            if (file_addr == port_b_addr) begin
                port_b <= write_data;
            end
            if (file_addr == port_c_addr) begin
                port_c <= write_data;
            end
        end
    end

    // ports read back their latch
    always_comb begin
        if (file_addr == port_b_addr) begin
            file_data = port_b;
        end else if (file_addr == port_c_addr) begin
            file_data = port_c;
        end else begin
            file_data = ram[file_addr];
        end
    end

endmodule

//--- src/fetch_unit.sv
module fetch_unit (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            pc_load,
    input  pic_pkg::pc_sel_t                pc_sel,
    input  logic                            mar_load,
    input  logic                            ir_load,
    input  logic                            ir_clear,
    input  logic [pic_pkg::pc_width-1:0]    stack_top,
    input  logic [pic_pkg::instr_width-1:0] rom_data,
    output logic [pic_pkg::pc_width-1:0]    pc,
    output logic [pic_pkg::pc_width-1:0]    mar,
    output logic [pic_pkg::instr_width-1:0] ir
);
    import pic_pkg::*;

    logic [pc_width-1:0] pc_next;

    always_comb begin
        unique case (pc_sel)
            pc_jump:  pc_next = ir[pc_width-1:0];
            pc_stack: pc_next = stack_top;
            default:  pc_next = pc + 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc  <= '0;
            mar <= '0;
        end else begin
            if (pc_load) begin
                pc <= pc_next;
            end
            if (mar_load) begin
                mar <= pc;
            end
        end
    end

    // a cleared word decodes as nop
    always_ff @(posedge clk) begin
        if (reset || ir_clear) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= rom_data;
        end
    end

endmodule

//--- src/call_stack.sv
module call_stack #(
    parameter int depth = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         push,
    input  logic                         pop,
    input  logic [pic_pkg::pc_width-1:0] return_addr,
    output logic [pic_pkg::pc_width-1:0] top
);
    import pic_pkg::*;

    localparam int idx_width = $clog2(depth);
    localparam int ptr_width = $clog2(depth + 1);

    logic [pc_width-1:0]  mem [depth];
    logic [ptr_width-1:0] ptr;
    logic [ptr_width-1:0] top_ptr;

    // ptr counts entries, top sits one below it
    assign top_ptr = ptr - 1'b1;
    assign top     = mem[top_ptr[idx_width-1:0]];

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (push) begin
            mem[ptr[idx_width-1:0]] <= return_addr;
            ptr <= ptr + 1'b1;
        end else if (pop) begin
            ptr <= ptr - 1'b1;
        end
    end

    overflow_check: assert property (@(posedge clk) disable iff (reset) push |-> ptr < depth);
    underflow_check: assert property (@(posedge clk) disable iff (reset) pop |-> ptr != 0);

endmodule

//--- src/program_rom.sv
module program_rom (
    input  logic                            clk,
    input  logic                            we,
    input  logic [pic_pkg::pc_width-1:0]    write_addr,
    input  logic [pic_pkg::instr_width-1:0] write_data,
    input  logic [pic_pkg::pc_width-1:0]    read_addr,
    output logic [pic_pkg::instr_width-1:0] read_data
);
    import pic_pkg::*;

    logic [instr_width-1:0] mem [2**pc_width];

    // loaded by the testbench while the core sits in reset
    always_ff @(posedge clk) begin
        if (we) begin
            mem[write_addr] <= write_data;
        end
    end

    assign read_data = mem[read_addr];

endmodule

//--- src/pic_pkg.sv
package pic_pkg;

    localparam int pc_width        = 11;
    localparam int instr_width     = 14;
    localparam int data_width      = 8;
    localparam int file_addr_width = 7;

    // output ports live in the file space
    localparam logic [file_addr_width-1:0] port_b_addr = 7'h0d;
    localparam logic [file_addr_width-1:0] port_c_addr = 7'h0e;

    // start-up fetch, then the three-cycle loop
    typedef enum logic [2:0] {
        fetch_clear,
        fetch_addr,
        fetch_wait,
        fetch_load,
        execute,
        redirect,
        prefetch
    } cycle_t;

    // sub is operand minus w
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_pass, alu_inc, alu_dec, alu_zero, alu_invert,
        alu_asr, alu_lsl, alu_lsr, alu_rl, alu_rr, alu_swap
    } alu_op_t;

    typedef enum logic [1:0] {
        pc_inc,
        pc_jump,
        pc_stack
    } pc_sel_t;

    typedef enum logic [1:0] {
        opnd_literal,
        opnd_file,
        opnd_bit_clear,
        opnd_bit_set
    } operand_sel_t;

endpackage
